/* Makefile */
TOOL    := verilator
FLAGS   := --binary --timing --assert -j 0
TOP     := tb_rv_mini
FLIST   := rv_mini.f
OBJDIR  := obj_dir
LOG     := sim.log
PASS    := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* core_ctrl_fsm.sv */
// ----------------------------------------
// Instruction sequencing FSM
// ----------------------------------------
`timescale 1ns/1ps

module core_ctrl_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_mini_pkg::opcode_e opcode,
    input  logic                 branch_taken,
    mem_bus_if.master            ibus,
    output logic                 dbus_req,
    output logic                 dbus_we,
    input  logic                 dbus_gnt,
    output logic                 pc_inc,
    output logic                 pc_load,
    output logic                 ir_load,
    output logic                 rf_we,
    output logic                 trap
);

    rv_mini_pkg::core_state_e state;
    rv_mini_pkg::core_state_e state_nxt;

    logic op_valid;
    logic op_mem;
    logic op_wr_rd;

    // Opcode classes
    always_comb begin
        op_valid = 1'b0;
        case (opcode)
            rv_mini_pkg::OP,
            rv_mini_pkg::OP_IMM,
            rv_mini_pkg::LUI,
            rv_mini_pkg::BRANCH,
            rv_mini_pkg::LOAD,
            rv_mini_pkg::STORE,
            rv_mini_pkg::JAL: op_valid = 1'b1;
            default:          op_valid = 1'b0;
        endcase
    end

    assign op_mem = (opcode == rv_mini_pkg::LOAD) || (opcode == rv_mini_pkg::STORE);

    // Branches and stores leave rd alone
    assign op_wr_rd = (opcode != rv_mini_pkg::BRANCH) && (opcode != rv_mini_pkg::STORE);

    // ----------------------------------------
    // Next state and strobes
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        ibus.req  = 1'b0;
        dbus_req  = 1'b0;
        dbus_we   = 1'b0;
        ir_load   = 1'b0;
        rf_we     = 1'b0;
        pc_inc    = 1'b0;
        pc_load   = 1'b0;
        case (state)
            rv_mini_pkg::FETCH: begin
                // Held here while the arbiter back-pressures
                ibus.req = 1'b1;
                if (ibus.gnt) begin
                    ir_load   = 1'b1;
                    state_nxt = rv_mini_pkg::DECODE;
                end
            end
            rv_mini_pkg::DECODE: begin
                state_nxt = op_valid ? rv_mini_pkg::EXECUTE : rv_mini_pkg::TRAP;
            end
            rv_mini_pkg::EXECUTE: begin
                state_nxt = op_mem ? rv_mini_pkg::MEMORY : rv_mini_pkg::WRITEBACK;
            end
            rv_mini_pkg::MEMORY: begin
                dbus_req = 1'b1;
                dbus_we  = (opcode == rv_mini_pkg::STORE);
                if (dbus_gnt) begin
                    state_nxt = rv_mini_pkg::WRITEBACK;
                end
            end
            rv_mini_pkg::WRITEBACK: begin
                rf_we     = op_wr_rd;
                pc_load   = branch_taken;
                pc_inc    = !branch_taken;
                state_nxt = rv_mini_pkg::FETCH;
            end
            default: begin
                // Sink until reset
                state_nxt = rv_mini_pkg::TRAP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rv_mini_pkg::FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    assign trap = (state == rv_mini_pkg::TRAP);

    // PC never both increments and loads
    a_pc_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({pc_inc, pc_load}));

endmodule

/* mem_arbiter.sv */
// ----------------------------------------
// Boot, data and instruction arbiter
// ----------------------------------------
`timescale 1ns/1ps

module mem_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,
    input  logic                           boot_we,
    input  logic [rv_mini_pkg::XLEN-1:0]   boot_addr,
    input  logic [rv_mini_pkg::XLEN-1:0]   boot_wdata,
    mem_bus_if.slave                       ibus,
    mem_bus_if.slave                       dbus,
    output logic                           mem_en,
    output logic                           mem_we,
    output logic [rv_mini_pkg::MEM_AW-1:0] mem_addr,
    output logic [rv_mini_pkg::XLEN-1:0]   mem_wdata,
    input  logic [rv_mini_pkg::XLEN-1:0]   mem_rdata
);

    logic boot_sel;
    logic d_sel;
    logic i_sel;
    logic d_gnt_q;
    logic i_gnt_q;

    // Fixed priority. A bus in its gnt cycle still holds req, mask it
    assign boot_sel = boot_we && !run;
    assign d_sel    = !boot_sel && dbus.req && !d_gnt_q;
    assign i_sel    = !boot_sel && !dbus.req && run && ibus.req && !i_gnt_q;

    // ----------------------------------------
    // Memory side
    // ----------------------------------------
    always_comb begin
        mem_en    = boot_sel || d_sel || i_sel;
        mem_we    = boot_sel || (d_sel && dbus.we);
        mem_wdata = boot_sel ? boot_wdata : dbus.wdata;
        if (boot_sel) begin
            mem_addr = boot_addr[2 +: rv_mini_pkg::MEM_AW];
        end else if (d_sel) begin
            mem_addr = dbus.addr[2 +: rv_mini_pkg::MEM_AW];
        end else begin
            mem_addr = ibus.addr[2 +: rv_mini_pkg::MEM_AW];
        end
    end

    // Grant one cycle after acceptance, with the read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_gnt_q <= 1'b0;
            i_gnt_q <= 1'b0;
        end else begin
            d_gnt_q <= d_sel;
            i_gnt_q <= i_sel;
        end
    end

    assign dbus.gnt   = d_gnt_q;
    assign ibus.gnt   = i_gnt_q;
    assign dbus.rdata = mem_rdata;
    assign ibus.rdata = mem_rdata;

    a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        !(ibus.gnt && dbus.gnt));

endmodule

/* mem_bus_if.sv */
// ----------------------------------------
// One memory request port, master and slave
// ----------------------------------------
`timescale 1ns/1ps

interface mem_bus_if;

    // Request side, held until gnt
    logic                         req;
    logic                         we;
    logic [rv_mini_pkg::XLEN-1:0] addr;
    logic [rv_mini_pkg::XLEN-1:0] wdata;

    // Response side, rdata valid with gnt
    logic [rv_mini_pkg::XLEN-1:0] rdata;
    logic                         gnt;

    modport master (
        output req, we, addr, wdata,
        input  rdata, gnt
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, gnt
    );

endinterface

/* pc_counter.sv */
// ----------------------------------------
// Program counter and retire count
// ----------------------------------------
`timescale 1ns/1ps

module pc_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pc_inc,
    input  logic                         pc_load,
    input  logic [rv_mini_pkg::XLEN-1:0] target,
    output logic [rv_mini_pkg::XLEN-1:0] pc,
    output logic [rv_mini_pkg::XLEN-1:0] retired
);

    // Load wins, the FSM never raises both
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_load) begin
            pc <= target;
        end else if (pc_inc) begin
            pc <= pc + 32'd4;
        end
    end

    // One strobe per completed instruction
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retired <= '0;
        end else if (pc_inc || pc_load) begin
            retired <= retired + 32'd1;
        end
    end

    // Targets come from decoded immediates, so alignment is not a given
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

/* rv_datapath.sv */
// ----------------------------------------
// Instruction register, immediates, register
// file, ALU and branch compare
// ----------------------------------------
`timescale 1ns/1ps

module rv_datapath (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ir_load,
    input  logic                         rf_we,
    input  logic [rv_mini_pkg::XLEN-1:0] ibus_rdata,
    input  logic [rv_mini_pkg::XLEN-1:0] pc,
    mem_bus_if.master                    dbus,
    output rv_mini_pkg::opcode_e         opcode,
    output logic                         branch_taken,
    output logic [rv_mini_pkg::XLEN-1:0] target
);

    logic [rv_mini_pkg::XLEN-1:0] ir_q;
    logic [rv_mini_pkg::XLEN-1:0] rf [32];

    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic       funct7_b5;

    logic [rv_mini_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [rv_mini_pkg::XLEN-1:0] a_q, b_q, alu_q, ld_q;
    logic [rv_mini_pkg::XLEN-1:0] op_b, alu_res, wb_data;
    logic                         cmp;

    // Instruction captured in the fetch gnt cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir_q <= rv_mini_pkg::NOP_INSTR;
        end else if (ir_load) begin
            ir_q <= ibus_rdata;
        end
    end

    assign opcode    = rv_mini_pkg::opcode_e'(ir_q[6:0]);
    assign rd        = ir_q[11:7];
    assign funct3    = ir_q[14:12];
    assign rs1       = ir_q[19:15];
    assign rs2       = ir_q[24:20];
    assign funct7_b5 = ir_q[30];

    // ----------------------------------------
    // Immediate decode
    // ----------------------------------------
    assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
    assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
    assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
    assign imm_u = {ir_q[31:12], 12'b0};
    assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

    // Register file, x0 reads as zero
    always_ff @(posedge clk) begin
        if (rf_we && (rd != 5'd0)) begin
            rf[rd] <= wb_data;
        end
    end

    // Operands settle in DECODE, result in EXECUTE
    always_ff @(posedge clk) begin
        a_q   <= (rs1 == 5'd0) ? '0 : rf[rs1];
        b_q   <= (rs2 == 5'd0) ? '0 : rf[rs2];
        alu_q <= alu_res;
    end

    // Load data only valid in the gnt cycle
    always_ff @(posedge clk) begin
        if (dbus.gnt) begin
            ld_q <= dbus.rdata;
        end
    end

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        if (opcode == rv_mini_pkg::OP) begin
            op_b = b_q;
        end else if (opcode == rv_mini_pkg::STORE) begin
            op_b = imm_s;
        end else begin
            op_b = imm_i;
        end
    end

    always_comb begin
        alu_res = a_q + op_b;
        if (opcode == rv_mini_pkg::LUI) begin
            alu_res = imm_u;
        end else if ((opcode == rv_mini_pkg::OP) || (opcode == rv_mini_pkg::OP_IMM)) begin
            case (funct3)
                rv_mini_pkg::F3_ADD_SUB: begin
                    // SUB only exists in the register form
                    if ((opcode == rv_mini_pkg::OP) && funct7_b5) begin
                        alu_res = a_q - op_b;
                    end
                end
                rv_mini_pkg::F3_SLL: alu_res = a_q << op_b[4:0];
                rv_mini_pkg::F3_XOR: alu_res = a_q ^ op_b;
                rv_mini_pkg::F3_OR:  alu_res = a_q | op_b;
                rv_mini_pkg::F3_AND: alu_res = a_q & op_b;
                default:             alu_res = a_q + op_b;
            endcase
        end
    end

    // Branch compare
    always_comb begin
        case (funct3)
            rv_mini_pkg::F3_BEQ: cmp = (a_q == b_q);
            rv_mini_pkg::F3_BNE: cmp = (a_q != b_q);
            rv_mini_pkg::F3_BLT: cmp = ($signed(a_q) < $signed(b_q));
            default:             cmp = 1'b0;
        endcase
    end

    assign branch_taken = (opcode == rv_mini_pkg::JAL) ||
                          ((opcode == rv_mini_pkg::BRANCH) && cmp);

    // PC-relative target, PC is stable until writeback
    assign target = pc + ((opcode == rv_mini_pkg::JAL) ? imm_j : imm_b);

    // Writeback select
    always_comb begin
        if (opcode == rv_mini_pkg::LOAD) begin
            wb_data = ld_q;
        end else if (opcode == rv_mini_pkg::JAL) begin
            wb_data = pc + 32'd4;
        end else begin
            wb_data = alu_q;
        end
    end

    // Address and store data held through MEMORY
    assign dbus.addr  = alu_q;
    assign dbus.wdata = b_q;

endmodule

/* rv_mini.f */
+incdir+.
rv_mini_pkg.sv
mem_bus_if.sv
core_ctrl_fsm.sv
pc_counter.sv
rv_datapath.sv
mem_arbiter.sv
spsram.sv
rv_mini_top.sv
tb_rv_mini.sv

/* rv_mini_pkg.sv */
// ----------------------------------------
// Core state and opcode enums, word sizes,
// memory map and funct3 codes
// ----------------------------------------
package rv_mini_pkg;

    // Data path and memory sizing
    localparam int XLEN      = 32;
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = 10;

    // Memory map, byte addresses
    localparam logic [XLEN-1:0] HALT_ADDR   = 32'd944;
    localparam logic [XLEN-1:0] RESULT_ADDR = 32'd960;
    localparam logic [XLEN-1:0] ARG_ADDR    = 32'd964;

    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // funct3 of the supported ALU ops
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 of the supported branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;

    // Instruction sequencing states
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        TRAP
    } core_state_e;

    // Major opcodes, anything else traps
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        JAL    = 7'b1101111
    } opcode_e;

endpackage

/* rv_mini_top.sv */
// ----------------------------------------
// Core, arbiter and memory with plain ports
// ----------------------------------------
`timescale 1ns/1ps

module rv_mini_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         run,
    input  logic                         boot_we,
    input  logic [rv_mini_pkg::XLEN-1:0] boot_addr,
    input  logic [rv_mini_pkg::XLEN-1:0] boot_wdata,
    output logic                         fetch_valid,
    output logic [rv_mini_pkg::XLEN-1:0] fetch_addr,
    output logic                         store_valid,
    output logic [rv_mini_pkg::XLEN-1:0] store_addr,
    output logic [rv_mini_pkg::XLEN-1:0] store_data,
    output logic                         trap
);

    mem_bus_if ibus ();
    mem_bus_if dbus ();

    rv_mini_pkg::opcode_e           opcode;
    logic                           branch_taken;
    logic                           dbus_req, dbus_we, dbus_gnt;
    logic                           pc_inc, pc_load, ir_load, rf_we;
    logic [rv_mini_pkg::XLEN-1:0]   pc, target, retired;
    logic                           mem_en, mem_we;
    logic [rv_mini_pkg::MEM_AW-1:0] mem_addr;
    logic [rv_mini_pkg::XLEN-1:0]   mem_wdata, mem_rdata;

    // Fetch port is read only, addressed by the PC
    assign ibus.addr  = pc;
    assign ibus.we    = 1'b0;
    assign ibus.wdata = '0;

    // FSM owns the data request, the datapath the payload
    assign dbus.req = dbus_req;
    assign dbus.we  = dbus_we;
    assign dbus_gnt = dbus.gnt;

    core_ctrl_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .opcode(opcode), .branch_taken(branch_taken),
        .ibus(ibus.master), .dbus_req(dbus_req), .dbus_we(dbus_we), .dbus_gnt(dbus_gnt),
        .pc_inc(pc_inc), .pc_load(pc_load), .ir_load(ir_load), .rf_we(rf_we), .trap(trap)
    );

    pc_counter u_pc (
        .clk(clk), .rst_n(rst_n), .pc_inc(pc_inc), .pc_load(pc_load),
        .target(target), .pc(pc), .retired(retired)
    );

    rv_datapath u_dp (
        .clk(clk), .rst_n(rst_n), .ir_load(ir_load), .rf_we(rf_we),
        .ibus_rdata(ibus.rdata), .pc(pc), .dbus(dbus.master),
        .opcode(opcode), .branch_taken(branch_taken), .target(target)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst_n(rst_n), .run(run),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_wdata(boot_wdata),
        .ibus(ibus.slave), .dbus(dbus.slave),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    spsram u_mem (
        .clk(clk), .en(mem_en), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata)
    );

    // Monitors, request fields are still held in the gnt cycle
    assign fetch_valid = ibus.gnt;
    assign fetch_addr  = ibus.addr;
    assign store_valid = dbus.gnt && dbus.we;
    assign store_addr  = dbus.addr;
    assign store_data  = dbus.wdata;

    // Every completed fetch is followed by decode
    a_fetch_decode: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |=> (u_fsm.state == rv_mini_pkg::DECODE));

    // No instruction retires once trapped
    a_trap_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        trap |=> $stable(retired));

endmodule

/* spsram.sv */
// ----------------------------------------
// Single-port word memory
// ----------------------------------------
`timescale 1ns/1ps

module spsram (
    input  logic                           clk,
    input  logic                           en,
    input  logic                           we,
    input  logic [rv_mini_pkg::MEM_AW-1:0] addr,
    input  logic [rv_mini_pkg::XLEN-1:0]   wdata,
    output logic [rv_mini_pkg::XLEN-1:0]   rdata
);

    logic [rv_mini_pkg::XLEN-1:0] mem [rv_mini_pkg::MEM_WORDS];

    // Write, or read with one cycle of latency
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

/* tb_rv_programs.svh */
// ----------------------------------------
// RV32 word encoders and program builders
// ----------------------------------------
`ifndef TB_RV_PROGRAMS_SVH
`define TB_RV_PROGRAMS_SVH

typedef logic [31:0] word_q_t [$];

// I-type, funct3 000
function automatic logic [31:0] addi_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
endfunction

// I-type load word, funct3 010
function automatic logic [31:0] lw_word(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

// S-type store word
function automatic logic [31:0] sw_word(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

// R-type ADD
function automatic logic [31:0] add_word(input int rd, input int rs1, input int rs2);
    return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
endfunction

// B-type, offset relative to this word
function automatic logic [31:0] branch_word(input logic [2:0] f3, input int rs1,
                                            input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
endfunction

// J-type
function automatic logic [31:0] jal_word(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
endfunction

// ----------------------------------------
// Program builders, each ends with a jump to the halt word
// ----------------------------------------

// x2 = 1, doubled x1 times, every step stored to the result word
function automatic word_q_t doubler_program();
    word_q_t p;
    p.push_back(lw_word(1, 0, int'(rv_mini_pkg::ARG_ADDR)));
    p.push_back(addi_word(2, 0, 1));
    p.push_back(sw_word(2, 0, int'(rv_mini_pkg::RESULT_ADDR)));
    // Loop body at byte 12
    p.push_back(add_word(2, 2, 2));
    p.push_back(sw_word(2, 0, int'(rv_mini_pkg::RESULT_ADDR)));
    p.push_back(addi_word(1, 1, -1));
    // bne x1, x0 back to byte 12
    p.push_back(branch_word(3'b001, 1, 0, -12));
    p.push_back(jal_word(0, int'(rv_mini_pkg::HALT_ADDR) - 28));
    return p;
endfunction

// a in RESULT_ADDR, b one word past ARG_ADDR, both reloaded every pass
function automatic word_q_t fibonacci_program();
    word_q_t p;
    p.push_back(lw_word(1, 0, int'(rv_mini_pkg::ARG_ADDR)));
    p.push_back(addi_word(3, 0, 0));
    p.push_back(addi_word(4, 0, 0));
    p.push_back(addi_word(5, 0, 1));
    p.push_back(sw_word(4, 0, int'(rv_mini_pkg::RESULT_ADDR)));
    p.push_back(sw_word(5, 0, int'(rv_mini_pkg::ARG_ADDR) + 4));
    // Loop body at byte 24
    p.push_back(lw_word(4, 0, int'(rv_mini_pkg::RESULT_ADDR)));
    p.push_back(lw_word(5, 0, int'(rv_mini_pkg::ARG_ADDR) + 4));
    p.push_back(add_word(6, 4, 5));
    p.push_back(sw_word(5, 0, int'(rv_mini_pkg::RESULT_ADDR)));
    p.push_back(sw_word(6, 0, int'(rv_mini_pkg::ARG_ADDR) + 4));
    p.push_back(addi_word(3, 3, 1));
    // blt x3, x1 back to byte 24
    p.push_back(branch_word(3'b100, 3, 1, -24));
    p.push_back(jal_word(0, int'(rv_mini_pkg::HALT_ADDR) - 52));
    return p;
endfunction

// Third word uses the custom-0 opcode
function automatic word_q_t trap_program();
    word_q_t p;
    p.push_back(addi_word(1, 0, 5));
    p.push_back(addi_word(2, 0, 7));
    p.push_back(32'h0000_000b);
    p.push_back(sw_word(1, 0, int'(rv_mini_pkg::RESULT_ADDR)));
    p.push_back(jal_word(0, int'(rv_mini_pkg::HALT_ADDR) - 16));
    return p;
endfunction

`endif

/* tb_rv_mini.sv */
// ----------------------------------------
// Testbench for the RV32 mini core subsystem
// ----------------------------------------
`timescale 1ns/1ps

module tb_rv_mini;

    `include "tb_rv_programs.svh"

    localparam int RUN_TIMEOUT = 6000;

    logic        clk;
    logic        rst_n;
    logic        run;
    logic        boot_we;
    logic [31:0] boot_addr;
    logic [31:0] boot_wdata;
    logic        fetch_valid;
    logic [31:0] fetch_addr;
    logic        store_valid;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic        trap;

    // Counters kept by the negedge monitor
    int          fetch_count = 0;
    int          store_count = 0;
    int          result_stores = 0;
    logic [31:0] last_result = '0;

    // Per-test bookkeeping
    string       test_name;
    logic        boot_phase;
    integer      seed;
    int          fetch_base;
    int          store_base;
    int          result_base;
    int          n;
    int          hold;
    word_q_t     prog;

    rv_mini_top dut (
        .clk(clk), .rst_n(rst_n), .run(run),
        .boot_we(boot_we), .boot_addr(boot_addr), .boot_wdata(boot_wdata),
        .fetch_valid(fetch_valid), .fetch_addr(fetch_addr),
        .store_valid(store_valid), .store_addr(store_addr), .store_data(store_data),
        .trap(trap)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------
    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("** Error [%s] %s: expected 0x%08h, actual 0x%08h", test_name, what, exp, act);
        stop_with_failure();
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in test %s while waiting for %s", test_name, what);
        stop_with_failure();
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else flag_mismatch(what, exp, act);
    endtask

    function automatic int pick_in_range(input int lo, input int span);
        return lo + int'({$random(seed)} % span);
    endfunction

    // Reference sequence in 32-bit arithmetic
    function automatic logic [31:0] fibonacci_of(input int count);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] t;
        a = 32'd0;
        b = 32'd1;
        for (int i = 0; i < count; i++) begin
            t = a + b;
            a = b;
            b = t;
        end
        return a;
    endfunction

    // Sample mid-cycle away from the DUT clock edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (fetch_valid) begin
                fetch_count <= fetch_count + 1;
            end
            if (store_valid) begin
                store_count <= store_count + 1;
                if (store_addr == rv_mini_pkg::RESULT_ADDR) begin
                    result_stores <= result_stores + 1;
                    last_result   <= store_data;
                end
            end
        end
    end

    // ----------------------------------------
    // Protocol assertions
    // ----------------------------------------
    // Nothing moves while the host is loading
    a_boot_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        boot_phase |-> !fetch_valid && !store_valid && !trap)
        else flag_mismatch("quiet during boot", 32'd0, {29'd0, fetch_valid, store_valid, trap});

    // A grant already in flight may land in the first low cycle
    a_run_low_no_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        (!run && !$past(run)) |-> !fetch_valid)
        else flag_mismatch("fetch while run low", 32'd0, {31'd0, fetch_valid});

    // Trapped core stays silent
    a_trap_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        trap |-> !fetch_valid && !store_valid)
        else flag_mismatch("activity after trap", 32'd0, {30'd0, fetch_valid, store_valid});

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic boot_write(input logic [31:0] addr, input logic [31:0] data);
        boot_we    = 1'b1;
        boot_addr  = addr;
        boot_wdata = data;
        @(posedge clk);
        #1;
    endtask

    // Reset and load with run low, then release the core
    task automatic start_program(input string name, input word_q_t words,
                                 input logic [31:0] arg);
        test_name = name;
        @(posedge clk);
        #1;
        run   = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n      = 1'b1;
        boot_phase = 1'b1;
        foreach (words[i]) begin
            boot_write(32'(i * 4), words[i]);
        end
        boot_write(rv_mini_pkg::ARG_ADDR, arg);
        // Self-jump that ends every program
        boot_write(rv_mini_pkg::HALT_ADDR, jal_word(0, 0));
        boot_we     = 1'b0;
        boot_phase  = 1'b0;
        fetch_base  = fetch_count;
        store_base  = store_count;
        result_base = result_stores;
        run         = 1'b1;
    endtask

    task automatic await_halt(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_on_timeout("the halt fetch");
            end
        end while (!(fetch_valid && (fetch_addr == rv_mini_pkg::HALT_ADDR)));
    endtask

    task automatic await_trap(input int limit);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_on_timeout("trap");
            end
        end while (!trap);
    endtask

    task automatic skip_fetches(input int count, input int limit);
        int cycles;
        int seen;
        cycles = 0;
        seen   = 0;
        while (seen < count) begin
            @(negedge clk);
            cycles++;
            if (fetch_valid) begin
                seen++;
            end
            if (cycles > limit) begin
                abort_on_timeout("fetches before the run drop");
            end
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst_n      = 1'b0;
        run        = 1'b0;
        boot_we    = 1'b0;
        boot_addr  = '0;
        boot_wdata = '0;
        boot_phase = 1'b0;
        test_name  = "reset";
        seed       = 32'hd69b_0d69;

        // Doubler gives 2 to the n
        n    = pick_in_range(1, 31);
        prog = doubler_program();
        start_program("doubler", prog, n);
        await_halt(RUN_TIMEOUT);
        check_value("result", 32'd1 << n, last_result);
        check_value("result stores", n + 1, result_stores - result_base);

        // Fibonacci with loads and stores in the loop
        n    = pick_in_range(1, 32);
        prog = fibonacci_program();
        start_program("fibonacci", prog, n);
        await_halt(RUN_TIMEOUT);
        check_value("result", fibonacci_of(n), last_result);
        check_value("result stores", n + 1, result_stores - result_base);

        // Doubler again with run dropped partway through
        n    = pick_in_range(1, 31);
        // Low long enough that the next FETCH falls inside the gap
        hold = pick_in_range(8, 15);
        prog = doubler_program();
        start_program("run drop", prog, n);
        skip_fetches(pick_in_range(2, 5), RUN_TIMEOUT);
        @(posedge clk);
        #1;
        run = 1'b0;
        repeat (hold) @(posedge clk);
        #1;
        run = 1'b1;
        await_halt(RUN_TIMEOUT);
        check_value("result", 32'd1 << n, last_result);

        // Unsupported opcode in the third word
        prog = trap_program();
        start_program("trap", prog, 32'd0);
        await_trap(RUN_TIMEOUT);
        repeat (30) @(posedge clk);
        #1;
        check_value("fetches", 32'd3, fetch_count - fetch_base);
        check_value("stores", 32'd0, store_count - store_base);
        check_value("trap level", 32'd1, {31'd0, trap});

        $display("All checks passed");
        $finish;
    end

endmodule
